// ==== rtl/mipsCore_macros.svh ====
// MIPS core width and address constants

`ifndef MIPSCORE_MACROS_SVH
`define MIPSCORE_MACROS_SVH

// data and address path, one word
`define WORD_WIDTH 32

`define REG_ADDR_BITS 5   // 32 registers

// fetch start and sequential step
`define RESET_PC 32'h0000_0000
`define PC_STEP 32'd4

`endif

// ==== rtl/isaPkg.sv ====
// MIPS-I subset encodings

package isaPkg;

   // primary opcodes, instr[31:26]
   typedef enum logic [5:0] {
      OP_RTYPE = 6'b000000,
      OP_J     = 6'b000010,
      OP_BEQ   = 6'b000100,
      OP_BNE   = 6'b000101,
      OP_ADDI  = 6'b001000,
      OP_ANDI  = 6'b001100,
      OP_ORI   = 6'b001101,
      OP_LUI   = 6'b001111,
      OP_LW    = 6'b100011,
      OP_SW    = 6'b101011
   } opcodeT;

   typedef enum logic [5:0] {
      FN_ADD = 6'b100000,
      FN_SUB = 6'b100010,
      FN_AND = 6'b100100,
      FN_OR  = 6'b100101
   } functT;   // R-type function field

   // ---------------------------------------------------------------------
   // field positions inside the instruction word
   // ---------------------------------------------------------------------
   localparam int OPCODE_MSB = 31;
   localparam int OPCODE_LSB = 26;
   localparam int RS_MSB     = 25;
   localparam int RS_LSB     = 21;
   localparam int RT_MSB     = 20;
   localparam int RT_LSB     = 16;
   localparam int RD_MSB     = 15;
   localparam int RD_LSB     = 11;
   localparam int FUNCT_MSB  = 5;
   localparam int FUNCT_LSB  = 0;
   localparam int IMM_MSB    = 15;
   localparam int IMM_LSB    = 0;
   localparam int TARGET_MSB = 25;
   localparam int TARGET_LSB = 0;

endpackage

// ==== rtl/ctrlPkg.sv ====
// controller types

package ctrlPkg;

   typedef enum logic [3:0] {
      S_FETCH,
      S_DECODE,
      S_MEMADR,
      S_LWRD,
      S_LWWR,
      S_SWWR,
      S_RTYPEEX,
      S_ALUWR,
      S_IMMEX,
      S_BRANCHEX,
      S_JEX
   } stateT;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_LUI} aluOpT;

   // second ALU operand, ZEROIMM serves andi and ori
   typedef enum logic [2:0] {
      SRCB_REG,
      SRCB_FOUR,
      SRCB_SIGNIMM,
      SRCB_BRANCHOFS,
      SRCB_ZEROIMM
   } srcBSelT;

   typedef enum logic [1:0] {PC_ALURESULT, PC_ALUOUT, PC_JUMPTARGET} pcSrcT;

   typedef enum logic {DST_RT, DST_RD} regDstT;

endpackage

// ==== rtl/ctrlIf.sv ====
// controller to datapath bundle

`timescale 1ns/1ps

interface ctrlIf;
   import isaPkg::*;
   import ctrlPkg::*;

   logic    irWrite;
   logic    pcEn;
   logic    regWrite;
   regDstT  regDst;
   logic    memToReg;   // write back from memory data register
   logic    iOrD;       // address from ALUOut instead of PC
   logic    aluSrcA;    // A register instead of PC
   srcBSelT aluSrcB;
   aluOpT   aluOp;
   pcSrcT   pcSource;

   // status back from the datapath
   opcodeT  opcode;
   functT   funct;
   logic    zero;

   modport ctrl (
      output irWrite, pcEn, regWrite, regDst, memToReg, iOrD,
      output aluSrcA, aluSrcB, aluOp, pcSource,
      input  opcode, funct, zero
   );

   modport dp (
      input  irWrite, pcEn, regWrite, regDst, memToReg, iOrD,
      input  aluSrcA, aluSrcB, aluOp, pcSource,
      output opcode, funct, zero
   );

endinterface

// ==== rtl/alu.sv ====
// ALU with zero flag

`timescale 1ns/1ps

`include "mipsCore_macros.svh"

module alu (
   input  logic [`WORD_WIDTH-1:0] a,
   input  logic [`WORD_WIDTH-1:0] b,
   input  ctrlPkg::aluOpT         op,
   output logic [`WORD_WIDTH-1:0] result,
   output logic                   zero
);
   import ctrlPkg::*;

   always_comb
   begin
      case (op)
         ALU_SUB: result = a - b;
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_LUI: result = {b[15:0], 16'b0};   // immediate to upper half
         default: result = a + b;
      endcase
   end

   assign zero = (result == '0);

endmodule

// ==== rtl/regFile.sv ====
// register file, two reads and one write

`timescale 1ns/1ps

`include "mipsCore_macros.svh"

module regFile (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      writeEn,
   input  logic [`REG_ADDR_BITS-1:0] readAddr1,
   input  logic [`REG_ADDR_BITS-1:0] readAddr2,
   input  logic [`REG_ADDR_BITS-1:0] writeAddr,
   input  logic [`WORD_WIDTH-1:0]    writeData,
   output logic [`WORD_WIDTH-1:0]    readData1,
   output logic [`WORD_WIDTH-1:0]    readData2
);

   logic [`WORD_WIDTH-1:0] regs [2**`REG_ADDR_BITS];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < 2**`REG_ADDR_BITS; i++)
            regs[i] <= '0;
      end
      else if (writeEn && writeAddr != '0)
         regs[writeAddr] <= writeData;
   end

   // $zero reads as zero
   assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
   assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// ==== rtl/controller.sv ====
// multicycle control FSM

`timescale 1ns/1ps

module controller (
   input  logic clk,
   input  logic reset,
   input  logic wbAck,
   output logic wbCyc,
   output logic wbStb,
   output logic wbWe,
   ctrlIf.ctrl  ctrl
);
   import isaPkg::*;
   import ctrlPkg::*;

   stateT state;
   stateT nextState;
   logic  pcWrite;    // unconditional PC load
   logic  branch;     // conditional PC load
   logic  useFunct;   // ALU op comes from the funct field
   aluOpT fixedOp;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= S_FETCH;
      else
         state <= nextState;
   end

   // ----------------------------------------------------------------------
   // next state
   // ----------------------------------------------------------------------
   always_comb
   begin
      nextState = S_FETCH;
      case (state)
         S_FETCH:    nextState = wbAck ? S_DECODE : S_FETCH;
         S_DECODE:
         begin
            case (ctrl.opcode)
               OP_LW, OP_SW:                   nextState = S_MEMADR;
               OP_RTYPE:                       nextState = S_RTYPEEX;
               OP_BEQ, OP_BNE:                 nextState = S_BRANCHEX;
               OP_J:                           nextState = S_JEX;
               OP_ADDI, OP_ANDI, OP_ORI, OP_LUI: nextState = S_IMMEX;
               default:                        nextState = S_FETCH;  // unknown op skipped
            endcase
         end
         S_MEMADR:   nextState = (ctrl.opcode == OP_LW) ? S_LWRD : S_SWWR;
         S_LWRD:     nextState = wbAck ? S_LWWR : S_LWRD;
         S_SWWR:     nextState = wbAck ? S_FETCH : S_SWWR;
         S_RTYPEEX:  nextState = S_ALUWR;
         S_IMMEX:    nextState = S_ALUWR;
         default:    nextState = S_FETCH;   // LWWR, ALUWR, BRANCHEX, JEX
      endcase
   end

   // ----------------------------------------------------------------------
   // per-state controls, all idle while reset is high
   // ----------------------------------------------------------------------
   always_comb
   begin
      wbCyc         = 1'b0;
      wbStb         = 1'b0;
      wbWe          = 1'b0;
      ctrl.irWrite  = 1'b0;
      ctrl.regWrite = 1'b0;
      ctrl.regDst   = DST_RT;
      ctrl.memToReg = 1'b0;
      ctrl.iOrD     = 1'b0;
      ctrl.aluSrcA  = 1'b0;
      ctrl.aluSrcB  = SRCB_REG;
      ctrl.pcSource = PC_ALURESULT;
      pcWrite       = 1'b0;
      branch        = 1'b0;
      useFunct      = 1'b0;
      fixedOp       = ALU_ADD;
      if (!reset)
      begin
         case (state)
            S_FETCH:
            begin
               wbCyc        = 1'b1;
               wbStb        = 1'b1;
               ctrl.irWrite = wbAck;
               ctrl.aluSrcB = SRCB_FOUR;   // pc + 4
               pcWrite      = wbAck;
            end
            S_DECODE:    ctrl.aluSrcB = SRCB_BRANCHOFS;   // branch target into ALUOut
            S_MEMADR, S_LWRD, S_SWWR:
            begin
               // address recomputed each cycle so ALUOut holds while waiting
               ctrl.aluSrcA = 1'b1;
               ctrl.aluSrcB = SRCB_SIGNIMM;
               if (state != S_MEMADR)
               begin
                  wbCyc     = 1'b1;
                  wbStb     = 1'b1;
                  wbWe      = (state == S_SWWR);
                  ctrl.iOrD = 1'b1;
               end
            end
            S_LWWR:
            begin
               ctrl.regWrite = 1'b1;
               ctrl.memToReg = 1'b1;
            end
            S_RTYPEEX:
            begin
               ctrl.aluSrcA = 1'b1;
               useFunct     = 1'b1;
            end
            S_IMMEX:
            begin
               ctrl.aluSrcA = 1'b1;
               ctrl.aluSrcB = SRCB_ZEROIMM;
               case (ctrl.opcode)
                  OP_ANDI: fixedOp = ALU_AND;
                  OP_ORI:  fixedOp = ALU_OR;
                  OP_LUI:  fixedOp = ALU_LUI;
                  default: ctrl.aluSrcB = SRCB_SIGNIMM;   // addi
               endcase
            end
            S_ALUWR:
            begin
               ctrl.regWrite = 1'b1;
               ctrl.regDst   = (ctrl.opcode == OP_RTYPE) ? DST_RD : DST_RT;
            end
            S_BRANCHEX:
            begin
               ctrl.aluSrcA  = 1'b1;
               fixedOp       = ALU_SUB;   // compare rs and rt
               ctrl.pcSource = PC_ALUOUT;
               branch        = 1'b1;
            end
            S_JEX:
            begin
               ctrl.pcSource = PC_JUMPTARGET;
               pcWrite       = 1'b1;
            end
            default: ;
         endcase
      end
   end

   // R-type op from funct, otherwise the state's own op
   always_comb
   begin
      ctrl.aluOp = fixedOp;
      if (useFunct)
      begin
         case (ctrl.funct)
            FN_SUB:  ctrl.aluOp = ALU_SUB;
            FN_AND:  ctrl.aluOp = ALU_AND;
            FN_OR:   ctrl.aluOp = ALU_OR;
            default: ctrl.aluOp = ALU_ADD;
         endcase
      end
   end

   // bne takes the branch on a nonzero difference
   assign ctrl.pcEn = pcWrite |
                      (branch & ((ctrl.opcode == OP_BNE) ? ~ctrl.zero : ctrl.zero));

endmodule

// ==== rtl/datapath.sv ====
// multicycle datapath

`timescale 1ns/1ps

`include "mipsCore_macros.svh"

module datapath (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`WORD_WIDTH-1:0] wbDatR,
   output logic [`WORD_WIDTH-1:0] wbAdr,
   output logic [`WORD_WIDTH-1:0] wbDatW,
   ctrlIf.dp                      dp
);
   import isaPkg::*;
   import ctrlPkg::*;

   logic [`WORD_WIDTH-1:0]   pc;
   logic [`WORD_WIDTH-1:0]   nextPc;
   logic [`WORD_WIDTH-1:0]   instr;
   logic [`WORD_WIDTH-1:0]   mdr;
   logic [`WORD_WIDTH-1:0]   aReg;
   logic [`WORD_WIDTH-1:0]   bReg;
   logic [`WORD_WIDTH-1:0]   aluOut;
   logic [`WORD_WIDTH-1:0]   aluResult;
   logic [`WORD_WIDTH-1:0]   srcA;
   logic [`WORD_WIDTH-1:0]   srcB;
   logic [`WORD_WIDTH-1:0]   rd1;
   logic [`WORD_WIDTH-1:0]   rd2;
   logic [`WORD_WIDTH-1:0]   signImm;
   logic [`WORD_WIDTH-1:0]   zeroImm;
   logic [`WORD_WIDTH-1:0]   branchOfs;
   logic [`WORD_WIDTH-1:0]   jumpTarget;
   logic [`WORD_WIDTH-1:0]   writeData;
   logic [`REG_ADDR_BITS-1:0] writeReg;

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= `RESET_PC;
      else if (dp.pcEn)
         pc <= nextPc;
   end

   always_ff @(posedge clk)
   begin
      if (dp.irWrite)
         instr <= wbDatR;
      mdr    <= wbDatR;   // only meaningful at the ack edge of LWRD
      aReg   <= rd1;
      bReg   <= rd2;
      aluOut <= aluResult;
   end

   assign dp.opcode = opcodeT'(instr[OPCODE_MSB:OPCODE_LSB]);
   assign dp.funct  = functT'(instr[FUNCT_MSB:FUNCT_LSB]);

   // ----------------------------------------------------------------------
   // immediates and targets
   // ----------------------------------------------------------------------
   assign signImm    = {{16{instr[IMM_MSB]}}, instr[IMM_MSB:IMM_LSB]};
   assign zeroImm    = {16'b0, instr[IMM_MSB:IMM_LSB]};
   assign branchOfs  = {signImm[`WORD_WIDTH-3:0], 2'b00};
   assign jumpTarget = {pc[31:28], instr[TARGET_MSB:TARGET_LSB], 2'b00};

   assign srcA = dp.aluSrcA ? aReg : pc;

   always_comb
   begin
      case (dp.aluSrcB)
         SRCB_FOUR:      srcB = `PC_STEP;
         SRCB_SIGNIMM:   srcB = signImm;
         SRCB_BRANCHOFS: srcB = branchOfs;
         SRCB_ZEROIMM:   srcB = zeroImm;
         default:        srcB = bReg;
      endcase
   end

   always_comb
   begin
      case (dp.pcSource)
         PC_ALUOUT:     nextPc = aluOut;
         PC_JUMPTARGET: nextPc = jumpTarget;
         default:       nextPc = aluResult;
      endcase
   end

   assign writeReg  = (dp.regDst == DST_RD) ? instr[RD_MSB:RD_LSB] : instr[RT_MSB:RT_LSB];
   assign writeData = dp.memToReg ? mdr : aluOut;

   assign wbAdr  = dp.iOrD ? aluOut : pc;
   assign wbDatW = bReg;   // rt value for sw

   alu u_alu (
      .a      (srcA),
      .b      (srcB),
      .op     (dp.aluOp),
      .result (aluResult),
      .zero   (dp.zero)
   );

   regFile u_regFile (
      .clk       (clk),
      .reset     (reset),
      .writeEn   (dp.regWrite),
      .readAddr1 (instr[RS_MSB:RS_LSB]),
      .readAddr2 (instr[RT_MSB:RT_LSB]),
      .writeAddr (writeReg),
      .writeData (writeData),
      .readData1 (rd1),
      .readData2 (rd2)
   );

endmodule

// ==== rtl/mipsCore.sv ====
// multicycle MIPS core, Wishbone master

`timescale 1ns/1ps

`include "mipsCore_macros.svh"

module mipsCore (
   input  logic                   clk,
   input  logic                   reset,
   output logic                   wbCyc,
   output logic                   wbStb,
   output logic                   wbWe,
   output logic [`WORD_WIDTH-1:0] wbAdr,
   output logic [`WORD_WIDTH-1:0] wbDatW,
   input  logic [`WORD_WIDTH-1:0] wbDatR,
   input  logic                   wbAck
);

   ctrlIf u_ctrlIf ();

   // bus strobes come from the FSM
   controller u_controller (
      .clk   (clk),
      .reset (reset),
      .wbAck (wbAck),
      .wbCyc (wbCyc),
      .wbStb (wbStb),
      .wbWe  (wbWe),
      .ctrl  (u_ctrlIf.ctrl)
   );

   // address and write data from the datapath
   datapath u_datapath (
      .clk    (clk),
      .reset  (reset),
      .wbDatR (wbDatR),
      .wbAdr  (wbAdr),
      .wbDatW (wbDatW),
      .dp     (u_ctrlIf.dp)
   );

endmodule

// ==== test/wbMemory.sv ====
// Wishbone slave memory with wait states

`timescale 1ns/1ps

module wbMemory #(
   parameter logic [31:0] preloadWord = 32'h0
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        cyc,
   input  logic        stb,
   input  logic        we,
   input  logic [31:0] adr,
   input  logic [31:0] datW,
   output logic [31:0] datR,
   output logic        ack
);
   import isaPkg::*;

   logic [31:0] mem [256];   // 1 KiB, word indexed
   logic        busy;
   int          waitLeft;

   function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input functT fn);
      return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] jType(input logic [25:0] target);
      return {OP_J, target};
   endfunction

   // ------------------------------------------------------------------
   // program image
   // ------------------------------------------------------------------
   initial
   begin
      ack      = 1'b0;
      datR     = '0;
      busy     = 1'b0;
      waitLeft = 0;
      for (int i = 0; i < 256; i++)
         mem[i] = 32'hBAD0_0000 | 32'(i * 4);   // fill tracks the byte address
      mem[64] = preloadWord;   // 0x100, source of the lw
      mem[0]  = iType(OP_ADDI, 5'd0, 5'd1, 16'hFFFB);    // r1 = -5
      mem[1]  = iType(OP_SW,   5'd0, 5'd1, 16'h0200);
      mem[2]  = iType(OP_ORI,  5'd0, 5'd2, 16'hF0F0);
      mem[3]  = iType(OP_SW,   5'd0, 5'd2, 16'h0204);
      mem[4]  = iType(OP_ANDI, 5'd1, 5'd3, 16'h00FF);
      mem[5]  = iType(OP_SW,   5'd0, 5'd3, 16'h0208);
      mem[6]  = iType(OP_LUI,  5'd0, 5'd4, 16'h1234);
      mem[7]  = iType(OP_SW,   5'd0, 5'd4, 16'h020C);
      mem[8]  = rType(5'd4, 5'd2, 5'd5, FN_ADD);
      mem[9]  = iType(OP_SW,   5'd0, 5'd5, 16'h0210);
      mem[10] = rType(5'd2, 5'd3, 5'd6, FN_SUB);
      mem[11] = iType(OP_SW,   5'd0, 5'd6, 16'h0214);
      mem[12] = rType(5'd5, 5'd2, 5'd7, FN_AND);
      mem[13] = iType(OP_SW,   5'd0, 5'd7, 16'h0218);
      mem[14] = rType(5'd4, 5'd3, 5'd8, FN_OR);
      mem[15] = iType(OP_SW,   5'd0, 5'd8, 16'h021C);
      mem[16] = iType(OP_LW,   5'd0, 5'd9, 16'h0100);
      mem[17] = iType(OP_ADDI, 5'd9, 5'd9, 16'h0001);
      mem[18] = iType(OP_SW,   5'd0, 5'd9, 16'h0220);
      mem[19] = iType(OP_BEQ,  5'd1, 5'd1, 16'h0001);    // taken
      mem[20] = iType(OP_SW,   5'd0, 5'd0, 16'h03F0);    // poison store
      mem[21] = iType(OP_BNE,  5'd1, 5'd1, 16'h0001);    // not taken
      mem[22] = iType(OP_SW,   5'd0, 5'd3, 16'h0224);
      mem[23] = jType(26'h000017);                       // j to itself at 0x5C
   end

   // acks change on the falling edge, the core samples on the rising one
   always @(negedge clk)
   begin
      if (reset)
      begin
         ack  = 1'b0;
         busy = 1'b0;
      end
      else
      begin
         if (ack)
         begin
            ack  = 1'b0;   // access closed at the last rising edge
            busy = 1'b0;
         end
         if (cyc && stb && !busy)
         begin
            busy     = 1'b1;
            waitLeft = $urandom % 4;   // 0 to 3 wait states
         end
         if (busy && waitLeft == 0)
         begin
            ack  = 1'b1;
            datR = mem[adr[9:2]];
            if (we)
               mem[adr[9:2]] = datW;
         end
         else if (busy)
            waitLeft--;
      end
   end

endmodule

// ==== test/tbMipsCore.sv ====
// testbench for the MIPS core

`timescale 1ns/1ps

module tbMipsCore;

   localparam int          NUM_STORES    = 10;
   localparam int          STORE_TIMEOUT = 4000;
   localparam int          SETTLE_CYCLES = 200;
   localparam logic [31:0] LOAD_WORD     = 32'h7654_3210;
   localparam logic [31:0] POISON_ADR    = 32'h0000_03F0;
   localparam logic [31:0] JUMP_ADR      = 32'h0000_005C;

   logic        clk;
   logic        reset;
   logic        wbCyc;
   logic        wbStb;
   logic        wbWe;
   logic [31:0] wbAdr;
   logic [31:0] wbDatW;
   logic [31:0] wbDatR;
   logic        wbAck;

   logic [31:0] expAdr [NUM_STORES];
   logic [31:0] expDat [NUM_STORES];
   logic        storeAcked = 1'b0;
   int          storeIdx = 0;      // stores seen so far
   int          jumpFetches = 0;   // acked accesses after the last store
   int          cycles;

   mipsCore u_dut (
      .clk    (clk),
      .reset  (reset),
      .wbCyc  (wbCyc),
      .wbStb  (wbStb),
      .wbWe   (wbWe),
      .wbAdr  (wbAdr),
      .wbDatW (wbDatW),
      .wbDatR (wbDatR),
      .wbAck  (wbAck)
   );

   wbMemory #(.preloadWord(LOAD_WORD)) u_memory (
      .clk  (clk),
      .reset(reset),
      .cyc  (wbCyc),
      .stb  (wbStb),
      .we   (wbWe),
      .adr  (wbAdr),
      .datW (wbDatW),
      .datR (wbDatR),
      .ack  (wbAck)
   );

   always #4 clk = ~clk;

   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic flagError(input string msg);
      abortRun($sformatf("** Error at %0t ns: %s", $time, msg));
   endtask

   // register values follow the MIPS semantics of the program
   task automatic fillStoreTable();
      logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8;
      r1 = 32'd0 - 32'd5;             // addi sign-extends
      r2 = 32'h0000_F0F0;             // ori zero-extends
      r3 = r1 & 32'h0000_00FF;        // andi zero-extends
      r4 = {16'h1234, 16'h0000};
      r5 = r4 + r2;
      r6 = r2 - r3;
      r7 = r5 & r2;
      r8 = r4 | r3;
      for (int i = 0; i < NUM_STORES; i++)
         expAdr[i] = 32'h0000_0200 + 32'(i * 4);
      expDat = '{r1, r2, r3, r4, r5, r6, r7, r8, LOAD_WORD + 32'd1, r3};
   endtask

   function automatic logic storeExpected(input int idx, input logic [31:0] adr,
                                          input logic [31:0] dat);
      if (idx >= NUM_STORES)
         return 1'b0;   // store beyond the table
      return adr == expAdr[idx] && dat == expDat[idx];
   endfunction

   // store count moves on the falling edge so the checks see it stable
   always @(posedge clk)
      storeAcked <= !reset && wbCyc && wbStb && wbWe && wbAck;

   always @(negedge clk)
   begin
      if (storeAcked)
         storeIdx <= storeIdx + 1;
   end

   // the final j keeps the core fetching
   always @(posedge clk)
   begin
      if (!reset && storeIdx == NUM_STORES && wbCyc && wbStb && wbAck)
         jumpFetches <= jumpFetches + 1;
   end

   // ------------------------------------------------------------------
   // bus and program checks
   // ------------------------------------------------------------------
   resetIdle: assert property (@(posedge clk) reset |-> !wbCyc && !wbStb)
      else flagError("bus active while reset is high");

   firstFetch: assert property (@(posedge clk)
      $fell(reset) |-> wbCyc && wbStb && !wbWe && wbAdr == 32'h0)
      else flagError("first access after reset is not a read at address 0");

   holdRequest: assert property (@(posedge clk) disable iff (reset)
      wbCyc && wbStb && !wbAck |=>
         $stable(wbAdr) && $stable(wbWe) && (!wbWe || $stable(wbDatW)))
      else flagError("request changed before ack");

   storeOrder: assert property (@(posedge clk) disable iff (reset)
      wbCyc && wbStb && wbWe && wbAck |-> storeExpected(storeIdx, wbAdr, wbDatW))
      else flagError("store address, data or order differs from the table");

   noPoison: assert property (@(posedge clk) disable iff (reset)
      wbCyc && wbStb && wbWe |-> wbAdr != POISON_ADR)
      else flagError("write to the poison address");

   parkedAtJump: assert property (@(posedge clk) disable iff (reset)
      storeIdx == NUM_STORES && wbCyc && wbStb |-> !wbWe && wbAdr == JUMP_ADR)
      else flagError("access other than the final j fetch after the last store");

   initial
   begin
      void'($urandom(16728));
      clk   = 1'b0;
      reset = 1'b1;
      fillStoreTable();
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      cycles = 0;
      while (storeIdx < NUM_STORES && cycles < STORE_TIMEOUT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (storeIdx < NUM_STORES)
         abortRun($sformatf("timed out after %0d of %0d stores", storeIdx, NUM_STORES));
      else
      begin
         // core spins on the final j
         cycles = 0;
         while (cycles < SETTLE_CYCLES)
         begin
            @(negedge clk);
            cycles++;
         end
         if (jumpFetches == 0)
            abortRun("core stopped fetching after the last store");
         else
         begin
            $display("STATUS: PASS");
            $finish;
         end
      end
   end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/ctrlIf.sv
rtl/alu.sv
rtl/regFile.sv
rtl/controller.sv
rtl/datapath.sv
rtl/mipsCore.sv
test/wbMemory.sv
test/tbMipsCore.sv

// ==== Makefile ====
# Verilator build and run of the MIPS core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tbMipsCore -Mdir obj_dir -f all.f
	./obj_dir/VtbMipsCore | tee $(LOG)
	@if grep -qx "STATUS: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
